// File: hdl/decode_pkg.sv
/*
 * Constant-operand decode package
 * Shared widths, opcode values and the micro-op field layout, with small
 * functions that pull each field out of a micro-op
 */

package decode_pkg;

	// ==============================
	// Widths
	// ==============================
	typedef logic [63:0]  word_t;
	typedef logic [31:0]  address_t;
	typedef logic [47:0]  micro_op_t;
	typedef logic [335:0] bundle_t;
	typedef logic [239:0] const_zone_t;
	typedef logic [3:0]   const_pos_t;
	typedef logic [1:0]   const_size_t;
	typedef logic [6:0]   opcode_t;
	typedef logic [4:0]   reg_idx_t;
	// Position in the low four bits, size code in the top two
	typedef logic [5:0]   const_desc_t;

	// Parcels 0 to 5 each give their upper 40 bits to the zone
	localparam int ZONE_PARCELS = 6;

	// ==============================
	// Opcodes
	// ==============================
	localparam opcode_t OP_R3    = 7'h02;
	localparam opcode_t OP_FLT   = 7'h03;
	localparam opcode_t OP_ADDI  = 7'h04;
	localparam opcode_t OP_SUBFI = 7'h05;
	localparam opcode_t OP_CMPI  = 7'h06;
	localparam opcode_t OP_ANDI  = 7'h08;
	localparam opcode_t OP_ORI   = 7'h09;
	localparam opcode_t OP_XORI  = 7'h0a;
	localparam opcode_t OP_CMPUI = 7'h0b;
	localparam opcode_t OP_LOADI = 7'h0c;
	localparam opcode_t OP_LOAD  = 7'h40;
	localparam opcode_t OP_LDIP  = 7'h44;
	localparam opcode_t OP_STORE = 7'h48;
	localparam opcode_t OP_STI   = 7'h4c;

	// ==============================
	// Field extraction
	// ==============================
	// Fields common to every form
	function automatic opcode_t fn_opcode(input micro_op_t op);
		return op[6:0];
	endfunction
	function automatic reg_idx_t fn_rs1(input micro_op_t op);
		return op[16:12];
	endfunction
	function automatic reg_idx_t fn_rs2(input micro_op_t op);
		return op[21:17];
	endfunction
	function automatic reg_idx_t fn_rs3(input micro_op_t op);
		return op[26:22];
	endfunction

	// ALU immediate form carries a 27 bit immediate
	function automatic logic [26:0] fn_alu_imm(input micro_op_t op);
		return op[43:17];
	endfunction

	// R3 and float forms locate their constants with three descriptors
	function automatic const_desc_t fn_desc_a(input micro_op_t op);
		return op[32:27];
	endfunction
	function automatic const_desc_t fn_desc_b(input micro_op_t op);
		return op[38:33];
	endfunction
	function automatic const_desc_t fn_desc_c(input micro_op_t op);
		return op[44:39];
	endfunction
	function automatic logic fn_has_a(input micro_op_t op);
		return op[45];
	endfunction
	function automatic logic fn_has_b(input micro_op_t op);
		return op[46];
	endfunction
	function automatic logic fn_has_c(input micro_op_t op);
		return op[47];
	endfunction

	// Load and store forms
	function automatic logic fn_ms(input micro_op_t op);
		return op[22];
	endfunction
	function automatic logic [18:0] fn_disp(input micro_op_t op);
		return op[41:23];
	endfunction
	function automatic const_desc_t fn_sti_desc(input micro_op_t op);
		return op[47:42];
	endfunction

	// Descriptor halves
	function automatic const_pos_t fn_desc_pos(input const_desc_t desc);
		return desc[3:0];
	endfunction
	function automatic const_size_t fn_desc_size(input const_desc_t desc);
		return desc[5:4];
	endfunction

endpackage

// File: hdl/decode_ifs.sv
/*
 * Constant decode interfaces
 * const_bus_if carries the unpacked zone constants and their size codes,
 * operand_if carries the selected operands and their constant flags
 */

interface const_bus_if
	import decode_pkg::*;
();
	// Four sign-extended constants, d is the store-immediate value
	word_t       cnst_a;
	word_t       cnst_b;
	word_t       cnst_c;
	word_t       cnst_d;
	// Size codes steer the float widening of a, b and c
	const_size_t size_a;
	const_size_t size_b;
	const_size_t size_c;

	modport src (output cnst_a, cnst_b, cnst_c, cnst_d, size_a, size_b, size_c);
	modport dst (input cnst_a, cnst_b, cnst_c, cnst_d, size_a, size_b, size_c);
endinterface

interface operand_if
	import decode_pkg::*;
();
	word_t imm_a;
	word_t imm_b;
	word_t imm_c;
	word_t imm_d;
	logic  has_a;
	logic  has_b;
	logic  has_c;
	logic  has_d;

	modport src (output imm_a, imm_b, imm_c, imm_d, has_a, has_b, has_c, has_d);
	modport dst (input imm_a, imm_b, imm_c, imm_d, has_a, has_b, has_c, has_d);
endinterface

// File: hdl/const_unpack.sv
/*
 * Constant zone unpacker
 * Builds the constant zone from the fetch bundle and extracts four
 * sign-extended constants by position and size code
 */

module const_unpack
	import decode_pkg::*;
#(
	parameter int ZONE_PARCELS = decode_pkg::ZONE_PARCELS
)
(
	input micro_op_t   micro_op,
	input bundle_t     bundle,
	const_bus_if.src   cb
);

	const_zone_t zone;
	const_desc_t desc_a;
	const_desc_t desc_b;
	const_desc_t desc_c;
	const_desc_t desc_d;

	// Take the field at pos*16 and sign-extend it by the size code
	// Bits shifted in from above the zone are zero
	function automatic word_t extract(input const_zone_t z, input const_desc_t desc);
		word_t raw;
		raw = word_t'(z >> {fn_desc_pos(desc), 4'b0000});
		case (fn_desc_size(desc))
		2'd0:    extract = {{56{raw[7]}}, raw[7:0]};
		2'd1:    extract = {{48{raw[15]}}, raw[15:0]};
		2'd2:    extract = {{32{raw[31]}}, raw[31:0]};
		default: extract = raw;
		endcase
	endfunction

	// Each zone parcel gives bits 47..8, the low byte holds opcode bits
	// Parcel 0 fills the bottom of the zone
	always_comb
	begin
		zone = '0;
		for (int p = 0; p < ZONE_PARCELS; p++)
			zone[p*40 +: 40] = bundle[p*48 + 8 +: 40];
	end

	// Three operand descriptors plus the store-immediate descriptor
	assign desc_a = fn_desc_a(micro_op);
	assign desc_b = fn_desc_b(micro_op);
	assign desc_c = fn_desc_c(micro_op);
	assign desc_d = fn_sti_desc(micro_op);

	assign cb.cnst_a = extract(zone, desc_a);
	assign cb.cnst_b = extract(zone, desc_b);
	assign cb.cnst_c = extract(zone, desc_c);
	assign cb.cnst_d = extract(zone, desc_d);

	// Size codes go along so the float path can pick a widened value
	assign cb.size_a = fn_desc_size(desc_a);
	assign cb.size_b = fn_desc_size(desc_b);
	assign cb.size_c = fn_desc_size(desc_c);

endmodule

// File: hdl/fp_widen.sv
/*
 * Float widening to double
 * Exact conversion of a half or single precision value to double,
 * covering subnormals, signed zeros, infinities and NaNs
 */

module fp_widen
	import decode_pkg::*;
#(
	parameter int SRC_WIDTH = 16
)
(
	input  word_t src,
	output word_t dst
);

	// Field widths of the source format
	localparam int EXP_W    = (SRC_WIDTH == 16) ? 5 : 8;
	localparam int FRAC_W   = (SRC_WIDTH == 16) ? 10 : 23;
	localparam int BIAS     = (1 << (EXP_W - 1)) - 1;
	// Difference between the double bias and the source bias
	localparam int BIAS_ADJ = 1023 - BIAS;

	logic              sign;
	logic [EXP_W-1:0]  exp_in;
	logic [FRAC_W-1:0] frac_in;
	logic [4:0]        lz;
	logic [FRAC_W-1:0] norm;
	logic [10:0]       exp_out;
	logic [51:0]       frac_out;

	// Only half and single sources are defined
	if (SRC_WIDTH != 16 && SRC_WIDTH != 32)
	begin : g_bad_width
		$error("fp_widen supports SRC_WIDTH of 16 or 32 only");
	end

	assign sign    = src[SRC_WIDTH-1];
	assign exp_in  = src[SRC_WIDTH-2 -: EXP_W];
	assign frac_in = src[FRAC_W-1:0];

	// Leading zero count of the fraction, the highest set bit wins
	always_comb
	begin
		lz = '0;
		for (int i = 0; i < FRAC_W; i++)
		begin
			if (frac_in[i])
				lz = 5'(FRAC_W - 1 - i);
		end
	end

	// Shift out the leading one so the rest becomes the double fraction
	assign norm = frac_in << (lz + 5'd1);

	always_comb
	begin
		if (exp_in == '1)
		begin
			// Infinity stays infinity, a NaN keeps its payload and turns quiet
			exp_out  = 11'h7ff;
			frac_out = {frac_in, {(52-FRAC_W){1'b0}}};
			if (frac_in != '0)
				frac_out[51] = 1'b1;
		end
		else if (exp_in == '0)
		begin
			if (frac_in == '0)
			begin
				// Signed zero, the sign bit passes through below
				exp_out  = '0;
				frac_out = '0;
			end
			else
			begin
				// Subnormal sources are normal in double
				exp_out  = 11'(BIAS_ADJ) - 11'(lz);
				frac_out = {norm, {(52-FRAC_W){1'b0}}};
			end
		end
		else
		begin
			exp_out  = 11'(exp_in) + 11'(BIAS_ADJ);
			frac_out = {frac_in, {(52-FRAC_W){1'b0}}};
		end
	end

	assign dst = {sign, exp_out, frac_out};

endmodule

// File: hdl/imm_select.sv
/*
 * Immediate operand selection
 * Chooses the four constant operand values and their flags from the
 * micro-op fields, the instruction pointer and the unpacked zone
 */

module imm_select
	import decode_pkg::*;
(
	input micro_op_t   micro_op,
	input address_t    ip,
	const_bus_if.dst   cb,
	input word_t       half_a,
	input word_t       half_b,
	input word_t       half_c,
	input word_t       single_a,
	input word_t       single_b,
	input word_t       single_c,
	operand_if.src     ops
);

	opcode_t     opcode;
	logic [26:0] alu_imm;
	logic [18:0] disp;
	word_t       disp_ext;

	// Float forms use the widened value for half and single sizes
	// Byte and double sized constants pass through as they are
	function automatic word_t pick_flt(
		input const_size_t size,
		input word_t       raw,
		input word_t       half,
		input word_t       single
	);
		case (size)
		2'd1:    pick_flt = half;
		2'd2:    pick_flt = single;
		default: pick_flt = raw;
		endcase
	endfunction

	assign opcode   = fn_opcode(micro_op);
	assign alu_imm  = fn_alu_imm(micro_op);
	assign disp     = fn_disp(micro_op);
	assign disp_ext = {{45{disp[18]}}, disp};

	always_comb
	begin
		ops.imm_a = '0;
		ops.imm_b = '0;
		ops.imm_c = '0;
		ops.imm_d = '0;
		ops.has_a = 1'b0;
		ops.has_b = 1'b0;
		ops.has_c = 1'b0;
		ops.has_d = 1'b0;

		case (opcode)
		// ==============================
		// ALU immediate forms
		// ==============================
		OP_ADDI, OP_SUBFI, OP_CMPI:
			begin
				ops.imm_b = {{37{alu_imm[26]}}, alu_imm};
				ops.has_b = 1'b1;
			end
		OP_ORI, OP_XORI, OP_CMPUI:
			begin
				ops.imm_b = {37'd0, alu_imm};
				ops.has_b = 1'b1;
			end
		// One-filled so the upper bits survive the and
		OP_ANDI:
			begin
				ops.imm_b = {{37{1'b1}}, alu_imm};
				ops.has_b = 1'b1;
			end
		// Load immediate is an add to a constant zero
		OP_LOADI:
			begin
				ops.imm_b = {{37{alu_imm[26]}}, alu_imm};
				ops.has_b = 1'b1;
				ops.has_a = 1'b1;
			end
		// ==============================
		// Three operand forms
		// ==============================
		OP_R3:
			begin
				ops.imm_a = cb.cnst_a;
				ops.imm_b = cb.cnst_b;
				ops.imm_c = cb.cnst_c;
				ops.has_a = fn_has_a(micro_op);
				ops.has_b = fn_has_b(micro_op);
				ops.has_c = fn_has_c(micro_op);
			end
		OP_FLT:
			begin
				ops.imm_a = pick_flt(cb.size_a, cb.cnst_a, half_a, single_a);
				ops.imm_b = pick_flt(cb.size_b, cb.cnst_b, half_b, single_b);
				ops.imm_c = pick_flt(cb.size_c, cb.cnst_c, half_c, single_c);
				ops.has_a = fn_has_a(micro_op);
				ops.has_b = fn_has_b(micro_op);
				ops.has_c = fn_has_c(micro_op);
			end
		// ==============================
		// Memory forms
		// ==============================
		OP_LOAD, OP_STORE, OP_LDIP, OP_STI:
			begin
				// Register zero as base or index reads as a constant zero
				if (fn_rs1(micro_op) == '0)
					ops.has_a = 1'b1;
				if (fn_rs2(micro_op) == '0)
					ops.has_b = 1'b1;
				// IP-relative load takes the pointer as its base
				if (opcode == OP_LDIP)
				begin
					ops.imm_a = {32'd0, ip};
					ops.has_a = 1'b1;
				end
				// Offset is a zone constant or the inline displacement
				ops.has_c = 1'b1;
				if (fn_ms(micro_op))
					ops.imm_c = cb.cnst_c;
				else
					ops.imm_c = disp_ext;
				// Store immediate carries its data as the d operand
				if (opcode == OP_STI)
				begin
					ops.imm_d = cb.cnst_d;
					ops.has_d = 1'b1;
				end
			end
		default:
			ops.imm_b = '0;
		endcase
	end

endmodule

// File: hdl/decode_ctrl.sv
/*
 * Constant decode pipeline control
 * Keeps the stage valid flags and derives the register enables from
 * hold, flush and reset
 */

module decode_ctrl
(
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic hold,
	input  logic flush,
	output logic load_s1,
	output logic load_s2,
	output logic out_valid
);

	logic valid_s1;
	logic valid_s2;

	// Stage registers only capture when there is something to take
	// and the pipe is free to move
	assign load_s1 = in_valid && !hold;
	assign load_s2 = valid_s1 && !hold;

	// Flush wins over hold, reset wins over both
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
		end
		else if (flush)
		begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
		end
		else if (!hold)
		begin
			valid_s1 <= in_valid;
			valid_s2 <= valid_s1;
		end
	end

	assign out_valid = valid_s2;

	// The source has to keep new micro-ops back while the pipe is held
	a_no_input_in_hold: assert property (
		@(posedge clk) disable iff (reset) hold |-> !in_valid
	) else $error("in_valid raised while hold is high");

	// Nothing in flight may come out after a flush
	a_flush_drops_output: assert property (
		@(posedge clk) disable iff (reset) flush |=> !out_valid
	) else $error("out_valid high in the cycle after a flush");

endmodule

// File: hdl/const_decode_top.sv
/*
 * Constant operand decode stage
 * Two-stage pipeline that turns a micro-op, its fetch bundle and its
 * instruction pointer into up to four constant operands
 */

module const_decode_top
	import decode_pkg::*;
#(
	parameter int ZONE_PARCELS = decode_pkg::ZONE_PARCELS
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      in_valid,
	input  micro_op_t micro_op,
	input  bundle_t   bundle,
	input  address_t  ip,
	input  logic      hold,
	input  logic      flush,
	output logic      out_valid,
	output word_t     imm_a,
	output word_t     imm_b,
	output word_t     imm_c,
	output word_t     imm_d,
	output logic      has_a,
	output logic      has_b,
	output logic      has_c,
	output logic      has_d
);

	logic      load_s1;
	logic      load_s2;
	micro_op_t s1_micro_op;
	bundle_t   s1_bundle;
	address_t  s1_ip;
	word_t     half_a;
	word_t     half_b;
	word_t     half_c;
	word_t     single_a;
	word_t     single_b;
	word_t     single_c;

	const_bus_if cb ();
	operand_if   ops ();

	decode_ctrl i_ctrl (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.hold      (hold),
		.flush     (flush),
		.load_s1   (load_s1),
		.load_s2   (load_s2),
		.out_valid (out_valid)
	);

	// ==============================
	// Stage 1 registers
	// ==============================
	always_ff @(posedge clk)
	begin
		if (load_s1)
		begin
			s1_micro_op <= micro_op;
			s1_bundle   <= bundle;
			s1_ip       <= ip;
		end
	end

	const_unpack #(.ZONE_PARCELS(ZONE_PARCELS)) i_unpack (
		.micro_op (s1_micro_op),
		.bundle   (s1_bundle),
		.cb       (cb)
	);

	// Half and single widening for each of the a, b and c lanes
	fp_widen #(.SRC_WIDTH(16)) i_half_a (.src(cb.cnst_a), .dst(half_a));
	fp_widen #(.SRC_WIDTH(16)) i_half_b (.src(cb.cnst_b), .dst(half_b));
	fp_widen #(.SRC_WIDTH(16)) i_half_c (.src(cb.cnst_c), .dst(half_c));
	fp_widen #(.SRC_WIDTH(32)) i_single_a (.src(cb.cnst_a), .dst(single_a));
	fp_widen #(.SRC_WIDTH(32)) i_single_b (.src(cb.cnst_b), .dst(single_b));
	fp_widen #(.SRC_WIDTH(32)) i_single_c (.src(cb.cnst_c), .dst(single_c));

	imm_select i_select (
		.micro_op (s1_micro_op),
		.ip       (s1_ip),
		.cb       (cb),
		.half_a   (half_a),
		.half_b   (half_b),
		.half_c   (half_c),
		.single_a (single_a),
		.single_b (single_b),
		.single_c (single_c),
		.ops      (ops)
	);

	// ==============================
	// Stage 2 output registers
	// ==============================
	always_ff @(posedge clk)
	begin
		if (load_s2)
		begin
			imm_a <= ops.imm_a;
			imm_b <= ops.imm_b;
			imm_c <= ops.imm_c;
			imm_d <= ops.imm_d;
			has_a <= ops.has_a;
			has_b <= ops.has_b;
			has_c <= ops.has_c;
			has_d <= ops.has_d;
		end
	end

endmodule

// File: bench/tb_vectors.svh
/*
 * Constant decode test vectors
 * One add_row call per test: name, micro-op, zone contents, zone use, ip,
 * expected a, b, c and d, then the expected flags as {a, b, c, d}
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_ROWS = 16;

task automatic load_vectors();
	// ==============================
	// ALU immediates
	// ==============================
	add_row(0, "addi_neg", alu_op(OP_ADDI, 27'h7fffffe), '0, 1'b0, 32'h0,
		64'h0, 64'hffffffff_fffffffe, 64'h0, 64'h0, 4'b0100);
	add_row(1, "ori_zext", alu_op(OP_ORI, 27'h7fffffe), '0, 1'b0, 32'h0,
		64'h0, 64'h00000000_07fffffe, 64'h0, 64'h0, 4'b0100);
	add_row(2, "andi_ones", alu_op(OP_ANDI, 27'h0000123), '0, 1'b0, 32'h0,
		64'h0, 64'hffffffff_f8000123, 64'h0, 64'h0, 4'b0100);
	add_row(3, "loadi", alu_op(OP_LOADI, 27'h0000042), '0, 1'b0, 32'h0,
		64'h0, 64'h00000000_00000042, 64'h0, 64'h0, 4'b1100);
	add_row(4, "cmpui_zext", alu_op(OP_CMPUI, 27'h4000000), '0, 1'b0, 32'h0,
		64'h0, 64'h00000000_04000000, 64'h0, 64'h0, 4'b0100);
	// ==============================
	// R3 and float constants
	// ==============================
	add_row(5, "r3_sizes", r3_op(OP_R3, 6'h30, 6'h04, 6'h15, 3'b101),
		{144'h0, 16'h7abc, 8'h00, 8'h80, 64'h81234567_89abcdef}, 1'b1, 32'h0,
		64'h81234567_89abcdef, 64'hffffffff_ffffff80, 64'h00000000_00007abc,
		64'h0, 4'b1010);
	// Position 13 ends at the top of the zone and position 14 runs past it
	add_row(6, "r3_zone_end", r3_op(OP_R3, 6'h2d, 6'h2e, 6'h3e, 3'b000),
		{16'h8001, 16'h1234, 208'h0}, 1'b1, 32'h0,
		64'hffffffff_80011234, 64'h00000000_00008001, 64'h00000000_00008001,
		64'h0, 4'b0000);
	add_row(7, "flt_half", r3_op(OP_FLT, 6'h10, 6'h11, 6'h12, 3'b111),
		{192'h0, 16'h8000, 16'h0001, 16'h3c00}, 1'b1, 32'h0,
		64'h3ff00000_00000000, 64'h3e700000_00000000, 64'h80000000_00000000,
		64'h0, 4'b1110);
	add_row(8, "flt_single", r3_op(OP_FLT, 6'h20, 6'h22, 6'h24, 3'b011),
		{144'h0, 32'hc0200000, 32'h7f800001, 32'h7f800000}, 1'b1, 32'h0,
		64'h7ff00000_00000000, 64'h7ff80000_20000000, 64'hc0040000_00000000,
		64'h0, 4'b1100);
	add_row(9, "flt_sub_inf_dbl", r3_op(OP_FLT, 6'h20, 6'h12, 6'h33, 3'b111),
		{128'h0, 64'hdeadbeef_01234567, 16'h7c00, 32'h00400000}, 1'b1, 32'h0,
		64'h38000000_00000000, 64'h7ff00000_00000000, 64'hdeadbeef_01234567,
		64'h0, 4'b1110);
	add_row(10, "flt_nan_byte", r3_op(OP_FLT, 6'h10, 6'h11, 6'h02, 3'b100),
		{200'h0, 8'h7f, 16'hbe00, 16'h7e01}, 1'b1, 32'h0,
		64'h7ff80400_00000000, 64'hbff80000_00000000, 64'h00000000_0000007f,
		64'h0, 4'b0010);
	// ==============================
	// Memory forms
	// ==============================
	add_row(11, "load_disp", mem_op(OP_LOAD, 5'd3, 5'd0, 19'h40000, 6'h00), '0, 1'b0,
		32'h0, 64'h0, 64'h0, 64'hffffffff_fffc0000, 64'h0, 4'b0110);
	add_row(12, "store_zone", mem_zone_op(OP_STORE, 5'd0, 5'd5, 6'h21),
		{192'h0, 32'hfedcba98, 16'h0}, 1'b1, 32'h0,
		64'h0, 64'h0, 64'hffffffff_fedcba98, 64'h0, 4'b1010);
	add_row(13, "ldip", mem_op(OP_LDIP, 5'd7, 5'd2, 19'h00123, 6'h00), '0, 1'b0,
		32'h80001000, 64'h00000000_80001000, 64'h0, 64'h00000000_00000123,
		64'h0, 4'b1010);
	add_row(14, "sti_d", mem_op(OP_STI, 5'd4, 5'd6, 19'h00010, 6'h32),
		{144'h0, 64'h01020304_05060708, 32'h0}, 1'b1, 32'h0,
		64'h0, 64'h0, 64'h00000000_00000010, 64'h01020304_05060708, 4'b0011);
	add_row(15, "unknown_op", alu_op(7'h7f, 27'h5555555), '0, 1'b0, 32'h0,
		64'h0, 64'h0, 64'h0, 64'h0, 4'b0000);
endtask

`endif

// File: bench/tb_const_decode.sv
/*
 * Constant decode testbench
 * Runs the vector table through the two-stage pipeline, then checks
 * hold, flush and the state right after reset
 */

module tb_const_decode
	import decode_pkg::*;
();

	logic      clk;
	logic      reset;
	logic      in_valid;
	micro_op_t micro_op;
	bundle_t   bundle;
	address_t  ip;
	logic      hold;
	logic      flush;
	logic      out_valid;
	word_t     imm_a;
	word_t     imm_b;
	word_t     imm_c;
	word_t     imm_d;
	logic      has_a;
	logic      has_b;
	logic      has_c;
	logic      has_d;

	int pass_count = 0;
	int fail_count = 0;
	bit test_bad = 0;

	const_decode_top #(.ZONE_PARCELS(ZONE_PARCELS)) i_dut (.*);

	// ==============================
	// Table storage and builders
	// ==============================
	`include "tb_vectors.svh"

	string       row_name [NUM_ROWS];
	micro_op_t   row_op [NUM_ROWS];
	const_zone_t row_zone [NUM_ROWS];
	bit          row_uses_zone [NUM_ROWS];
	address_t    row_ip [NUM_ROWS];
	word_t       row_exp [NUM_ROWS][4];
	logic [3:0]  row_flags [NUM_ROWS];

	task automatic add_row(input int idx, input string name, input micro_op_t op,
		input const_zone_t zone, input bit uses_zone, input address_t ip_val,
		input word_t ea, input word_t eb, input word_t ec, input word_t ed,
		input logic [3:0] flags);
		row_name[idx] = name;
		row_op[idx] = op;
		row_zone[idx] = zone;
		row_uses_zone[idx] = uses_zone;
		row_ip[idx] = ip_val;
		row_exp[idx] = '{ea, eb, ec, ed};
		row_flags[idx] = flags;
	endtask

	// ALU form with rd 1 and rs1 2
	function automatic micro_op_t alu_op(input opcode_t opc, input logic [26:0] imm);
		return {4'h0, imm, 5'd2, 5'd1, opc};
	endfunction

	// Float and R3 form, flags given as {c, b, a}
	function automatic micro_op_t r3_op(input opcode_t opc, input logic [5:0] da,
		input logic [5:0] db, input logic [5:0] dc, input logic [2:0] flags);
		return {flags, dc, db, da, 5'd3, 5'd2, 5'd1, 5'd1, opc};
	endfunction

	// Memory form with an inline displacement, ms clear
	function automatic micro_op_t mem_op(input opcode_t opc, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [18:0] disp, input logic [5:0] sti);
		return {sti, disp, 1'b0, rs2, rs1, 5'd1, opc};
	endfunction

	// Memory form taking c from the zone, ms set
	function automatic micro_op_t mem_zone_op(input opcode_t opc, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [5:0] desc_c);
		micro_op_t op;
		op = {26'h0, rs2, rs1, 5'd1, opc};
		op[22] = 1'b1;
		op[44:39] = desc_c;
		return op;
	endfunction

	// Random parcels, then the zone goes into bits 47..8 of the zone parcels
	function automatic bundle_t build_bundle(input int idx);
		bundle_t b;
		for (int p = 0; p < 7; p++)
			b[p*48 +: 48] = 48'({$urandom, $urandom});
		if (row_uses_zone[idx])
			for (int p = 0; p < ZONE_PARCELS; p++)
				b[p*48 + 8 +: 40] = row_zone[idx][p*40 +: 40];
		return b;
	endfunction

	// ==============================
	// Drive and check
	// ==============================
	task automatic drive_row(input int idx);
		micro_op = row_op[idx];
		bundle = build_bundle(idx);
		ip = row_ip[idx];
		in_valid = 1'b1;
	endtask

	task automatic check_word(input string name, input string field,
		input word_t exp, input word_t act);
		if (act !== exp)
		begin
			$display("Fail %s %s expected %h actual %h", name, field, exp, act);
			test_bad = 1;
		end
	endtask

	// The result of row idx has to be on the outputs right now
	task automatic check_row(input int idx);
		if (out_valid !== 1'b1)
		begin
			$display("Test %s: out_valid was low when its result was due", row_name[idx]);
			test_bad = 1;
		end
		else
		begin
			check_word(row_name[idx], "imm_a", row_exp[idx][0], imm_a);
			check_word(row_name[idx], "imm_b", row_exp[idx][1], imm_b);
			check_word(row_name[idx], "imm_c", row_exp[idx][2], imm_c);
			check_word(row_name[idx], "imm_d", row_exp[idx][3], imm_d);
			check_word(row_name[idx], "flags", 64'(row_flags[idx]),
				64'({has_a, has_b, has_c, has_d}));
		end
	endtask

	task automatic finish_test(input string name);
		if (test_bad)
		begin
			fail_count++;
			$display("Test %s failed", name);
		end
		else
		begin
			pass_count++;
			$display("Test %s passed", name);
		end
		test_bad = 0;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Roughly twice the time the whole run needs
	initial
	begin
		#(NUM_ROWS * 8 + 200);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h6bc62c5f));
		load_vectors();
		reset = 1'b1;
		in_valid = 1'b0;
		micro_op = '0;
		bundle = '0;
		ip = '0;
		hold = 1'b0;
		flush = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		if (out_valid !== 1'b0)
		begin
			$display("Test reset: out_valid was high right after reset");
			test_bad = 1;
		end
		finish_test("reset");

		// ==============================
		// Table, one row per cycle
		// ==============================
		// Results of row k come out two edges after it is driven
		for (int k = 0; k < NUM_ROWS + 2; k++)
		begin
			step();
			if (k < NUM_ROWS)
				drive_row(k);
			else
				in_valid = 1'b0;
			if (k >= 2)
			begin
				check_row(k - 2);
				finish_test(row_name[k - 2]);
			end
		end

		// Hold two cycles with row 0 on the outputs and row 1 in stage 1
		step();
		drive_row(0);
		step();
		drive_row(1);
		step();
		in_valid = 1'b0;
		hold = 1'b1;
		check_row(0);
		step();
		check_row(0);
		step();
		check_row(0);
		hold = 1'b0;
		step();
		check_row(1);
		finish_test("hold");

		// Flush with row 2 in stage 1, nothing may come out after it
		step();
		drive_row(2);
		step();
		in_valid = 1'b0;
		flush = 1'b1;
		step();
		flush = 1'b0;
		for (int n = 0; n < 3; n++)
		begin
			if (out_valid !== 1'b0)
			begin
				$display("Test flush: out_valid high after the flush");
				test_bad = 1;
			end
			step();
		end
		finish_test("flush");

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+bench
hdl/decode_pkg.sv
hdl/decode_ifs.sv
hdl/const_unpack.sv
hdl/fp_widen.sv
hdl/imm_select.sv
hdl/decode_ctrl.sv
hdl/const_decode_top.sv
bench/tb_const_decode.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the constant decode testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_const_decode \
	-o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "Build or run error, see build.log and sim.log"; exit 1; }

grep -q "Simulation completed successfully" sim.log &&
echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }
